//--- hdl/mips_pkg.sv
package mips_pkg;

    // ------------------------------------------------------------------------
    // basic widths and constants
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t RESET_PC = 32'hBFC0_0000;
    localparam word_t NOP_WORD = 32'h0000_0000;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    // SPECIAL function codes, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_MFHI = 6'h10,
        FN_MFLO = 6'h12,
        FN_DIVU = 6'h1B,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // execute operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_DIV_START, ALU_READ_HI, ALU_READ_LO, ALU_NONE
    } alu_op_e;

    // ------------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_out_t;

    typedef struct packed {
        word_t      pc;
        alu_op_e    alu_op;
        word_t      src_a;
        word_t      src_b;
        logic [4:0] shamt;
        reg_idx_t   dest;
        logic       writes;
    } issue_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t dest;
        word_t    data;
        logic     writes;
    } retire_t;

endpackage

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [32];

    // $0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, $0 reads as zero
    always_comb begin
        rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
        rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];
    end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       decode_allowin,
    input  word_t      inst_sram_rdata,
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_wen,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    output logic       fetch_valid,
    output fetch_out_t fetch_out
);

    // address of the request whose data returns this cycle
    word_t req_pc;
    logic  req_pending;
    logic  capture;

    // returned word is taken when the fetch register is free or draining
    assign capture = req_pending && (!fetch_valid || decode_allowin);

    // on a capture move on to the next word, otherwise re-issue the same one
    assign inst_sram_addr = capture ? req_pc + 32'd4 : req_pc;

    // fetch always keeps one read in flight
    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pc      <= RESET_PC;
            req_pending <= 1'b0;
        end else begin
            req_pc      <= inst_sram_addr;
            req_pending <= inst_sram_en;
        end
    end

    // fetch pipeline register
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= capture || (fetch_valid && !decode_allowin);
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_out <= '{pc: req_pc, instr: inst_sram_rdata};
        end
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetch_valid,
    input  fetch_out_t fetch_out,
    output logic       decode_allowin,
    input  logic       exec_allowin,
    output logic       issue_valid,
    output issue_t     issue,
    input  retire_t    fwd_exec,
    input  logic       fwd_exec_valid,
    input  retire_t    retire,
    input  logic       retire_valid
);

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    rf_a;
    word_t    rf_b;
    word_t    imm_ext;
    logic     use_imm;
    logic     zero_ext;
    issue_t   next_issue;

    assign opcode = opcode_e'(fetch_out.instr[31:26]);
    assign funct  = funct_e'(fetch_out.instr[5:0]);
    assign rs     = fetch_out.instr[25:21];
    assign rt     = fetch_out.instr[20:16];
    assign rd     = fetch_out.instr[15:11];

    regfile u_regfile (
        .clk     ( clk                           ),
        .raddr_a ( rs                            ),
        .raddr_b ( rt                            ),
        .rdata_a ( rf_a                          ),
        .rdata_b ( rf_b                          ),
        .we      ( retire_valid && retire.writes ),
        .waddr   ( retire.dest                   ),
        .wdata   ( retire.data                   )
    );

    // newest producer wins: execute, then writeback, then regfile
    function automatic word_t bypass(reg_idx_t idx, word_t rf_val, retire_t ex,
                                     logic ex_valid, retire_t wb, logic wb_valid);
        if (ex_valid && ex.writes && ex.dest == idx) begin
            return ex.data;
        end else if (wb_valid && wb.writes && wb.dest == idx) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    // ------------------------------------------------------------------------
    // instruction decode
    // ------------------------------------------------------------------------
    always_comb begin
        next_issue        = '0;
        next_issue.pc     = fetch_out.pc;
        next_issue.alu_op = ALU_NONE;
        next_issue.shamt  = fetch_out.instr[10:6];
        next_issue.dest   = rd;
        use_imm           = 1'b0;
        zero_ext          = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                next_issue.writes = 1'b1;
                case (funct)
                    FN_ADDU: next_issue.alu_op = ALU_ADD;
                    FN_SUBU: next_issue.alu_op = ALU_SUB;
                    FN_AND:  next_issue.alu_op = ALU_AND;
                    FN_OR:   next_issue.alu_op = ALU_OR;
                    FN_XOR:  next_issue.alu_op = ALU_XOR;
                    FN_NOR:  next_issue.alu_op = ALU_NOR;
                    FN_SLT:  next_issue.alu_op = ALU_SLT;
                    FN_SLTU: next_issue.alu_op = ALU_SLTU;
                    FN_SLL:  next_issue.alu_op = ALU_SLL;
                    FN_SRL:  next_issue.alu_op = ALU_SRL;
                    FN_SRA:  next_issue.alu_op = ALU_SRA;
                    FN_MFHI: next_issue.alu_op = ALU_READ_HI;
                    FN_MFLO: next_issue.alu_op = ALU_READ_LO;
                    FN_DIVU: begin
                        next_issue.alu_op = ALU_DIV_START;
                        next_issue.writes = 1'b0;
                    end
                    default: next_issue.writes = 1'b0;
                endcase
            end
            OP_ADDIU: next_issue.alu_op = ALU_ADD;
            OP_SLTI:  next_issue.alu_op = ALU_SLT;
            OP_ANDI:  next_issue.alu_op = ALU_AND;
            OP_ORI:   next_issue.alu_op = ALU_OR;
            OP_XORI:  next_issue.alu_op = ALU_XOR;
            OP_LUI:   next_issue.alu_op = ALU_LUI;
            default:  next_issue.alu_op = ALU_NONE;
        endcase
        // immediate forms write rt
        if (opcode != OP_SPECIAL && next_issue.alu_op != ALU_NONE) begin
            use_imm           = 1'b1;
            zero_ext          = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                                (opcode == OP_XORI) || (opcode == OP_LUI);
            next_issue.dest   = rt;
            next_issue.writes = 1'b1;
        end
        // $0 destination never writes
        if (next_issue.dest == '0) begin
            next_issue.writes = 1'b0;
        end
        imm_ext = zero_ext ? {16'h0, fetch_out.instr[15:0]}
                           : {{16{fetch_out.instr[15]}}, fetch_out.instr[15:0]};
        next_issue.src_a = bypass(rs, rf_a, fwd_exec, fwd_exec_valid, retire, retire_valid);
        next_issue.src_b = use_imm ? imm_ext
                         : bypass(rt, rf_b, fwd_exec, fwd_exec_valid, retire, retire_valid);
    end

    // ------------------------------------------------------------------------
    // decode/execute register
    // ------------------------------------------------------------------------
    assign decode_allowin = !issue_valid || exec_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (decode_allowin) begin
            issue_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && decode_allowin) begin
            issue <= next_issue;
        end
    end

endmodule

//--- hdl/divider.sv
`timescale 1ns/1ps

module divider import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output logic  busy,
    output logic  done,
    output word_t quotient,
    output word_t remainder
);

    typedef enum logic {IDLE, RUN} div_state_e;

    div_state_e  state;
    logic [4:0]  count;
    word_t       div_reg;
    logic [32:0] partial;
    logic [33:0] diff;

    // one restoring step: shift in the next dividend bit, try subtracting
    assign partial = {remainder, quotient[31]};
    assign diff    = {1'b0, partial} - {2'b00, div_reg};

    // result stays held until the cycle after done
    assign busy = (state == RUN) || done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= (state == RUN) && (count == 5'd31);
            if (state == IDLE && start) begin
                state <= RUN;
                count <= '0;
            end else if (state == RUN) begin
                count <= count + 5'd1;
                if (count == 5'd31) begin
                    state <= IDLE;
                end
            end
        end
    end

    // quotient bits shift in from the bottom as dividend bits leave the top
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            quotient  <= dividend;
            remainder <= '0;
            div_reg   <= divisor;
        end else if (state == RUN) begin
            quotient  <= {quotient[30:0], !diff[33]};
            remainder <= diff[33] ? partial[31:0] : diff[31:0];
        end
    end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue_valid,
    input  issue_t  issue,
    output logic    exec_allowin,
    output retire_t fwd_exec,
    output logic    fwd_exec_valid,
    output retire_t retire,
    output logic    retire_valid
);

    word_t hi;
    word_t lo;
    word_t alu_result;
    logic  div_busy;
    logic  div_done;
    logic  div_start;
    logic  uses_hilo;
    logic  hold;
    word_t div_quotient;
    word_t div_remainder;

    // ------------------------------------------------------------------------
    // HI/LO and divider control
    // ------------------------------------------------------------------------
    assign uses_hilo = (issue.alu_op == ALU_DIV_START) || (issue.alu_op == ALU_READ_HI) ||
                       (issue.alu_op == ALU_READ_LO);
    assign hold      = issue_valid && uses_hilo && div_busy;
    assign div_start = issue_valid && (issue.alu_op == ALU_DIV_START) && !div_busy;

    // writeback register never back-pressures
    assign exec_allowin = !issue_valid || !hold;

    divider u_divider (
        .clk       ( clk           ),
        .reset     ( reset         ),
        .start     ( div_start     ),
        .dividend  ( issue.src_a   ),
        .divisor   ( issue.src_b   ),
        .busy      ( div_busy      ),
        .done      ( div_done      ),
        .quotient  ( div_quotient  ),
        .remainder ( div_remainder )
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            hi <= div_remainder;
            lo <= div_quotient;
        end
    end

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (issue.alu_op)
            ALU_ADD:     alu_result = issue.src_a + issue.src_b;
            ALU_SUB:     alu_result = issue.src_a - issue.src_b;
            ALU_AND:     alu_result = issue.src_a & issue.src_b;
            ALU_OR:      alu_result = issue.src_a | issue.src_b;
            ALU_XOR:     alu_result = issue.src_a ^ issue.src_b;
            ALU_NOR:     alu_result = ~(issue.src_a | issue.src_b);
            ALU_SLT:     alu_result = {31'b0, $signed(issue.src_a) < $signed(issue.src_b)};
            ALU_SLTU:    alu_result = {31'b0, issue.src_a < issue.src_b};
            ALU_SLL:     alu_result = issue.src_b << issue.shamt;
            ALU_SRL:     alu_result = issue.src_b >> issue.shamt;
            ALU_SRA:     alu_result = $signed(issue.src_b) >>> issue.shamt;
            ALU_LUI:     alu_result = {issue.src_b[15:0], 16'h0000};
            ALU_READ_HI: alu_result = hi;
            ALU_READ_LO: alu_result = lo;
            default:     alu_result = '0;
        endcase
    end

    assign fwd_exec = '{pc: issue.pc, dest: issue.dest, data: alu_result, writes: issue.writes};
    assign fwd_exec_valid = issue_valid && !hold;

    // writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= issue_valid && !hold;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && !hold) begin
            retire <= fwd_exec;
        end
    end

endmodule

//--- hdl/mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_sram_en,
    output logic [3:0] inst_sram_wen,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic       fetch_valid;
    fetch_out_t fetch_out;
    logic       decode_allowin;
    logic       issue_valid;
    issue_t     issue;
    logic       exec_allowin;
    retire_t    fwd_exec;
    logic       fwd_exec_valid;
    retire_t    retire;
    logic       retire_valid;

    fetch_stage u_fetch_stage (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .decode_allowin  ( decode_allowin  ),
        .inst_sram_rdata ( inst_sram_rdata ),
        .inst_sram_en    ( inst_sram_en    ),
        .inst_sram_wen   ( inst_sram_wen   ),
        .inst_sram_addr  ( inst_sram_addr  ),
        .inst_sram_wdata ( inst_sram_wdata ),
        .fetch_valid     ( fetch_valid     ),
        .fetch_out       ( fetch_out       )
    );

    decode_stage u_decode_stage (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .fetch_valid    ( fetch_valid    ),
        .fetch_out      ( fetch_out      ),
        .decode_allowin ( decode_allowin ),
        .exec_allowin   ( exec_allowin   ),
        .issue_valid    ( issue_valid    ),
        .issue          ( issue          ),
        .fwd_exec       ( fwd_exec       ),
        .fwd_exec_valid ( fwd_exec_valid ),
        .retire         ( retire         ),
        .retire_valid   ( retire_valid   )
    );

    execute_stage u_execute_stage (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .issue_valid    ( issue_valid    ),
        .issue          ( issue          ),
        .exec_allowin   ( exec_allowin   ),
        .fwd_exec       ( fwd_exec       ),
        .fwd_exec_valid ( fwd_exec_valid ),
        .retire         ( retire         ),
        .retire_valid   ( retire_valid   )
    );

    // debug trace taken straight from the writeback register
    assign debug_wb_pc       = retire.pc;
    assign debug_wb_rf_wen   = {4{retire_valid && retire.writes}};
    assign debug_wb_rf_wnum  = retire.dest;
    assign debug_wb_rf_wdata = retire.data;

endmodule

//--- verification/program_model.svh
`ifndef PROGRAM_MODEL_SVH
`define PROGRAM_MODEL_SVH

// ------------------------------------------------------------------------
// instruction encoders
// ------------------------------------------------------------------------
function automatic word_t r_type(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                 logic [4:0] sa);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic word_t i_type(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// mostly a small pool so that neighbours share registers
function automatic reg_idx_t pick_reg();
    if ({$random(seed)} % 4 != 0) begin
        return reg_idx_t'({$random(seed)} % 6);
    end
    return reg_idx_t'($random(seed));
endfunction

function automatic funct_e alu_funct(int sel);
    case (sel)
        0:       return FN_ADDU;
        1:       return FN_SUBU;
        2:       return FN_AND;
        3:       return FN_OR;
        4:       return FN_XOR;
        5:       return FN_NOR;
        6:       return FN_SLT;
        7:       return FN_SLTU;
        8:       return FN_SLL;
        9:       return FN_SRL;
        default: return FN_SRA;
    endcase
endfunction

function automatic opcode_e imm_opcode(int sel);
    case (sel)
        0:       return OP_ADDIU;
        1:       return OP_SLTI;
        2:       return OP_ANDI;
        3:       return OP_ORI;
        4:       return OP_XORI;
        default: return OP_LUI;
    endcase
endfunction

// ------------------------------------------------------------------------
// random program
// ------------------------------------------------------------------------
task automatic build_program();
    int          k;
    int          kind;
    logic        div_seen;
    logic        after_div;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] imm;
    div_seen  = 1'b0;
    after_div = 1'b0;
    // every register gets a defined value first
    for (k = 0; k < 31; k++) begin
        prog[k] = i_type(OP_ADDIU, 5'd0, reg_idx_t'(k + 1), 16'($random(seed)));
    end
    for (k = 31; k < PROG_LEN; k++) begin
        kind = {$random(seed)} % 20;
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        imm  = 16'($random(seed));
        // hi/lo reads often land right behind a divide
        if (after_div && kind < 10) begin
            kind = 19;
        end
        after_div = 1'b0;
        if (kind < 8) begin
            prog[k] = r_type(alu_funct(kind), rs, rt, rd, 5'd0);
        end else if (kind < 11) begin
            prog[k] = r_type(alu_funct(kind), 5'd0, rt, rd, imm[10:6]);
        end else if (kind < 17) begin
            prog[k] = i_type(imm_opcode(kind - 11), rs, rt, imm);
        end else if (kind < 19) begin
            if (imm[15:14] == 2'b00) begin
                rt = '0;
            end
            prog[k]   = r_type(FN_DIVU, rs, rt, 5'd0, 5'd0);
            div_seen  = 1'b1;
            after_div = 1'b1;
        end else if (div_seen) begin
            prog[k] = r_type(imm[0] ? FN_MFHI : FN_MFLO, 5'd0, 5'd0, rd, 5'd0);
        end else begin
            prog[k] = i_type(OP_ADDIU, rs, rt, imm);
        end
    end
endtask

// ------------------------------------------------------------------------
// architectural model, one entry per register write
// ------------------------------------------------------------------------
task automatic run_model();
    word_t    regs [32];
    word_t    hi;
    word_t    lo;
    word_t    a;
    word_t    b;
    word_t    sx;
    word_t    zx;
    word_t    res;
    word_t    ins;
    reg_idx_t dst;
    logic     wr;
    int       k;
    retire_t  entry;
    for (k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    hi = '0;
    lo = '0;
    for (k = 0; k < PROG_LEN; k++) begin
        ins = prog[k];
        a   = regs[ins[25:21]];
        b   = regs[ins[20:16]];
        sx  = {{16{ins[15]}}, ins[15:0]};
        zx  = {16'h0000, ins[15:0]};
        res = '0;
        wr  = 1'b1;
        dst = ins[15:11];
        if (ins[31:26] == OP_SPECIAL) begin
            case (ins[5:0])
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_NOR:  res = ~(a | b);
                FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                FN_SLTU: res = {31'b0, a < b};
                FN_SLL:  res = b << ins[10:6];
                FN_SRL:  res = b >> ins[10:6];
                FN_SRA:  res = $signed(b) >>> ins[10:6];
                FN_MFHI: res = hi;
                FN_MFLO: res = lo;
                FN_DIVU: begin
                    wr = 1'b0;
                    // zero divisor gives all ones and the dividend back
                    lo = (b == '0) ? '1 : a / b;
                    hi = (b == '0) ? a : a % b;
                end
                default: wr = 1'b0;
            endcase
        end else begin
            dst = ins[20:16];
            case (ins[31:26])
                OP_ADDIU: res = a + sx;
                OP_SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
                OP_ANDI:  res = a & zx;
                OP_ORI:   res = a | zx;
                OP_XORI:  res = a ^ zx;
                OP_LUI:   res = {ins[15:0], 16'h0000};
                default:  wr = 1'b0;
            endcase
        end
        if (wr && dst != '0) begin
            regs[dst]    = res;
            entry.pc     = RESET_PC + 32'(k * 4);
            entry.dest   = dst;
            entry.data   = res;
            entry.writes = 1'b1;
            expected.push_back(entry);
        end
    end
endtask

function automatic logic is_hilo_read(word_t pc);
    word_t idx;
    idx = (pc - RESET_PC) >> 2;
    if (idx >= PROG_LEN) begin
        return 1'b0;
    end
    return (prog[idx][31:26] == OP_SPECIAL) &&
           (prog[idx][5:0] == FN_MFHI || prog[idx][5:0] == FN_MFLO);
endfunction

`endif

//--- verification/tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline import mips_pkg::*; ();

    localparam int  PROG_LEN     = 200;
    localparam int  WAIT_LIMIT   = 20000;
    localparam int  DRAIN_CYCLES = 100;
    localparam time DRIVE_DELAY  = 1;

    logic       clk;
    logic       reset;
    logic       inst_sram_en;
    logic [3:0] inst_sram_wen;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    integer  seed;
    word_t   prog [PROG_LEN];
    retire_t expected [$];
    word_t   req_addr;
    logic    req_en;
    word_t   last_addr;
    logic    fetch_started;
    int      reset_errs;
    int      fetch_errs;
    int      alu_errs;
    int      zero_errs;
    int      div_errs;
    int      done_errs;
    int      hilo_reads;
    int      tests_run;
    int      tests_failed;

    `include "program_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mips_pipeline u_mips_pipeline (
        .clk               ( clk               ),
        .reset             ( reset             ),
        .inst_sram_en      ( inst_sram_en      ),
        .inst_sram_wen     ( inst_sram_wen     ),
        .inst_sram_addr    ( inst_sram_addr    ),
        .inst_sram_wdata   ( inst_sram_wdata   ),
        .inst_sram_rdata   ( inst_sram_rdata   ),
        .debug_wb_pc       ( debug_wb_pc       ),
        .debug_wb_rf_wen   ( debug_wb_rf_wen   ),
        .debug_wb_rf_wnum  ( debug_wb_rf_wnum  ),
        .debug_wb_rf_wdata ( debug_wb_rf_wdata )
    );

    // ------------------------------------------------------------------------
    // compare and report helpers
    // ------------------------------------------------------------------------
    task automatic check_word(word_t got, word_t exp, string what, inout int errs);
        if (got !== exp) begin
            errs++;
            $display("FAIL @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(reg_idx_t got, reg_idx_t exp, string what, inout int errs);
        if (got !== exp) begin
            errs++;
            $display("FAIL @ %0d ns: %s is r%0d, expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name, int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %-28s passed", name);
        end else begin
            tests_failed++;
            $display("test %-28s failed with %0d errors", name, errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // instruction SRAM model, one cycle read latency
    // ------------------------------------------------------------------------
    function automatic word_t read_imem(word_t addr);
        word_t offset;
        offset = addr - RESET_PC;
        if (offset[1:0] == 2'b00 && offset < PROG_LEN * 4) begin
            return prog[offset[31:2]];
        end
        return NOP_WORD;
    endfunction

    initial begin
        inst_sram_rdata = NOP_WORD;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (req_en) begin
                inst_sram_rdata = read_imem(req_addr);
            end
        end
    end

    // ------------------------------------------------------------------------
    // monitors, sampled mid-cycle
    // ------------------------------------------------------------------------
    task automatic observe_write();
        retire_t exp;
        int      errs;
        errs = 0;
        if (debug_wb_rf_wnum == '0) begin
            zero_errs++;
            $display("register 0 was written at pc %h, time %0t", debug_wb_pc, $time);
        end
        if (expected.size() == 0) begin
            done_errs++;
            $display("extra register write at pc %h after the last expected one, time %0t",
                     debug_wb_pc, $time);
            return;
        end
        exp = expected.pop_front();
        check_word(word_t'(debug_wb_rf_wen), 32'h0000_000F, "debug_wb_rf_wen", errs);
        check_word(debug_wb_pc, exp.pc, "debug_wb_pc", errs);
        check_reg(debug_wb_rf_wnum, exp.dest, "debug_wb_rf_wnum", errs);
        check_word(debug_wb_rf_wdata, exp.data, "debug_wb_rf_wdata", errs);
        if (is_hilo_read(exp.pc)) begin
            hilo_reads++;
            div_errs += errs;
        end else begin
            alu_errs += errs;
        end
    endtask

    always @(negedge clk) begin
        req_addr = inst_sram_addr;
        req_en   = inst_sram_en;
        if (inst_sram_en) begin
            if (!fetch_started) begin
                check_word(inst_sram_addr, RESET_PC, "first fetch address", reset_errs);
            end else if (inst_sram_addr != last_addr) begin
                check_word(inst_sram_addr, last_addr + 32'd4, "next fetch address",
                           fetch_errs);
            end
            fetch_started = 1'b1;
            last_addr     = inst_sram_addr;
        end
        check_word(word_t'(inst_sram_wen), '0, "inst_sram_wen", fetch_errs);
        check_word(inst_sram_wdata, '0, "inst_sram_wdata", fetch_errs);
        if (reset) begin
            check_word(word_t'(debug_wb_rf_wen), '0, "debug_wb_rf_wen in reset", reset_errs);
        end else if (debug_wb_rf_wen != 4'b0000) begin
            observe_write();
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int cycles;
        seed          = 32'h87ed_fe87;
        reset         = 1'b1;
        fetch_started = 1'b0;
        reset_errs    = 0;
        fetch_errs    = 0;
        alu_errs      = 0;
        zero_errs     = 0;
        div_errs      = 0;
        done_errs     = 0;
        hilo_reads    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        check_word(word_t'(debug_wb_rf_wen), '0, "debug_wb_rf_wen after reset", reset_errs);
        report_test("reset", reset_errs);

        cycles = 0;
        while (expected.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            done_errs++;
            $display("timeout after %0d cycles with %0d expected register writes missing",
                     cycles, expected.size());
        end else begin
            // stray writes would show up within a few pipeline depths
            cycles = 0;
            while (cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
        end
        if (hilo_reads == 0) begin
            div_errs++;
            $display("no MFHI or MFLO result was observed on the debug ports");
        end

        report_test("sequential fetch", fetch_errs);
        report_test("alu results with forwarding", alu_errs);
        report_test("register zero", zero_errs);
        report_test("divide through hi/lo", div_errs);
        report_test("completion", done_errs);
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verification
hdl/mips_pkg.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/divider.sv
hdl/execute_stage.sv
hdl/mips_pipeline.sv
verification/tb_mips_pipeline.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - hdl/mips_pkg.sv
  - hdl/regfile.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/divider.sv
  - hdl/execute_stage.sv
  - hdl/mips_pipeline.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_mips_pipeline.sv
